// File: Makefile
TOOL       = verilator
TOP        = vec_addsub_tb
FILELIST   = vec_addsub_unit.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

# static checks only, no executable
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, the exit status of the run is the verdict
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/vec_addsub_tb.sv
// ----------------------------------------
// testbench for the vector add/sub unit
// runs at VLEN 256, so one op takes 4 chunks
// inputs change 1 ns after the rising edge
// results are sampled on the falling edge
// ----------------------------------------
`timescale 1ns/1ps

module vec_addsub_tb
    import vec_pkg::*;
;

    localparam int VLEN         = 256;
    localparam int N_CHUNK      = VLEN / 64;
    localparam int VM_W         = VLEN / 8;
    localparam int DONE_TIMEOUT = 4 * N_CHUNK + 10; // cycles allowed per op

    logic              clk;
    logic              rst_n;
    logic              start;
    instr_type_t       instr_type;
    sew_t              sew;
    logic              use_mask;
    logic [VLEN-1:0]   vs1;
    logic [VLEN-1:0]   vs2;
    logic [VM_W-1:0]   vm;
    logic              busy;
    logic              done;
    logic [VLEN-1:0]   vd;
    logic [31:0]       lcg_state = 32'hd334;
    logic              tracking;        // an accepted op is in flight
    int                since_start;     // edges after the start edge

    vec_clk_gen #(.PERIOD_NS(8)) clk_gen_i (.clk_o(clk));

    vec_addsub_unit #(.VLEN(VLEN)) dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .instr_type_i (instr_type),
        .sew_i        (sew),
        .use_mask_i   (use_mask),
        .vs1_i        (vs1),
        .vs2_i        (vs2),
        .vm_i         (vm),
        .busy_o       (busy),
        .done_o       (done),
        .vd_o         (vd)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [VLEN-1:0] rand_vec();
        logic [VLEN-1:0] v;
        v = '0;
        for (int i = 0; i < VLEN / 32; i++) begin
            v = (v << 32) | VLEN'(lcg_next());
        end
        return v;
    endfunction

    // expected vd computed element by element at full precision
    function automatic logic [VLEN-1:0] expected_vd(input instr_type_t op, input sew_t s,
            input logic um, input logic [VLEN-1:0] a1, input logic [VLEN-1:0] a2,
            input logic [VM_W-1:0] m);
        int              w;
        int              ne;
        logic [64:0]     emask;
        logic [64:0]     x;      // vs1 element
        logic [64:0]     y;      // vs2 element
        logic [64:0]     r;
        logic [64:0]     cin;
        logic [VLEN-1:0] res;
        w     = 8 << s;
        ne    = VLEN / w;
        emask = (65'd1 << w) - 65'd1;
        res   = '1; // mask results keep ones above the element count
        for (int k = 0; k < ne; k++) begin
            x   = {1'b0, 64'(a1 >> (k * w))} & emask;
            y   = {1'b0, 64'(a2 >> (k * w))} & emask;
            cin = {64'd0, m[k]};
            case (op)
                VADD:    r = y + x;
                VSUB:    r = y - x;
                VRSUB:   r = x - y;
                VADC:    r = y + x + cin;
                VSBC:    r = y - x - cin;
                VMADC:   r = {64'd0, (y + x + (um ? cin : 65'd0)) > emask}; // sum >= 2^w
                VMSBC:   r = {64'd0, (x + (um ? cin : 65'd0)) > y};         // went below zero
                default: r = '0;
            endcase
            if (op == VMADC || op == VMSBC) begin
                res[k] = r[0];
            end else begin
                for (int b = 0; b < w; b++) begin
                    res[k * w + b] = r[b]; // wraps modulo 2^w
                end
            end
        end
        return res;
    endfunction

    // edges counted from the accepted start edge only
    always @(posedge clk) begin
        if (!rst_n) begin
            tracking    <= 1'b0;
            since_start <= 0;
        end else if (start && !busy) begin
            tracking    <= 1'b1;
            since_start <= 0;
        end else if (done) begin
            tracking    <= 1'b0;
        end else if (tracking) begin
            since_start <= since_start + 1;
        end
    end

    done_at_n_plus_1: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> since_start == N_CHUNK + 1)
        else report_failure("done_o did not come N+1 cycles after the start edge");
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else report_failure("done_o stayed high for more than one cycle");
    done_only_once: assert property (@(posedge clk) disable iff (!rst_n) done |-> tracking)
        else report_failure("done_o pulsed without an operation in flight");
    busy_low_at_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else report_failure("busy_o still high while done_o is high");
    busy_during_run: assert property (@(posedge clk) disable iff (!rst_n)
        (tracking && !done) |-> busy)
        else report_failure("busy_o dropped before the operation finished");

    // one op with an optional ignored start and new inputs while busy
    task automatic run_op(input instr_type_t op, input sew_t s, input logic um,
            input logic [VLEN-1:0] a1, input logic [VLEN-1:0] a2,
            input logic [VM_W-1:0] m, input logic disturb);
        logic [VLEN-1:0] exp_vd;
        logic            got_done;
        exp_vd = expected_vd(op, s, um, a1, a2, m);
        @(posedge clk);
        #1;
        instr_type = op;
        sew        = s;
        use_mask   = um;
        vs1        = a1;
        vs2        = a2;
        vm         = m;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (disturb) begin
            start      = 1'b1; // dropped since the unit is busy
            instr_type = (op == VADD) ? VSUB : VADD;
            sew        = sew_t'(s ^ 2'd1);
            use_mask   = ~um;
            vs1        = ~a1;
            vs2        = rand_vec();
            vm         = ~m;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        got_done = 1'b0;
        for (int c = 0; c < DONE_TIMEOUT && !got_done; c++) begin
            @(negedge clk);
            got_done = done;
        end
        if (!got_done) begin
            report_failure($sformatf("timeout at %0t ns, done_o never came for op %s",
                                     $time, op.name()));
        end else begin
            assert (vd === exp_vd)
            else report_failure($sformatf("ERROR %0t vd_o (%s %s) expected %h actual %h",
                                          $time, op.name(), s.name(), exp_vd, vd));
        end
    endtask

    initial begin
        logic [VLEN-1:0] a1;
        logic [VLEN-1:0] a2;
        logic [VM_W-1:0] m;
        rst_n      = 1'b0;
        start      = 1'b0;
        instr_type = VADD;
        sew        = SEW_8;
        use_mask   = 1'b0;
        vs1        = '0;
        vs2        = '0;
        vm         = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0)
        else report_failure($sformatf("ERROR %0t busy_o expected 0 actual %b", $time, busy));
        assert (done === 1'b0)
        else report_failure($sformatf("ERROR %0t done_o expected 0 actual %b", $time, done));
        assert (vd === '0)
        else report_failure($sformatf("ERROR %0t vd_o expected 0 actual %h", $time, vd));

        // all opcodes, widths and use_mask values with random and full ripple patterns
        for (int o = 0; o < 7; o++) begin
            for (int s = 0; s < 4; s++) begin
                for (int u = 0; u < 2; u++) begin
                    for (int p = 0; p < 3; p++) begin
                        case (p)
                            0: begin
                                a1 = rand_vec();
                                a2 = rand_vec();
                                m  = VM_W'(lcg_next());
                            end
                            1: begin
                                a1 = '0; // ones + 0 + carry ripples all the way
                                a2 = '1;
                                m  = '1;
                            end
                            default: begin
                                a1 = '1; // 0 - ones borrows all the way
                                a2 = '0;
                                m  = '1;
                            end
                        endcase
                        run_op(instr_type_t'(o), sew_t'(s), (u == 1), a1, a2, m, 1'b0);
                    end
                end
            end
        end

        // ignored start and changed inputs while busy
        for (int s = 0; s < 4; s++) begin
            a1 = rand_vec();
            a2 = rand_vec();
            m  = VM_W'(lcg_next());
            run_op(VSBC, sew_t'(s), 1'b0, a1, a2, m, 1'b1);
            run_op(VMADC, sew_t'(s), 1'b1, a2, a1, m, 1'b1);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: bench/vec_clk_gen.sv
// ----------------------------------------
// free-running testbench clock
// starts low at time zero, period in ns
// ----------------------------------------
`timescale 1ns/1ps

module vec_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o; // half period per toggle

endmodule

// File: source/vaddsub.sv
// ----------------------------------------
// one-chunk adder/subtractor, combinational
// eight byte adders, chained per element width
// mask ops return carry/borrow bits in the low
// n bits, every other bit of the result is one
// ----------------------------------------
`timescale 1ns/1ps

module vaddsub
    import vec_pkg::*;
(
    input  instr_type_t instr_type_i, // operation
    input  sew_t        sew_i,        // element width
    input  bus64_t      data_vs1_i,   // chunk of vs1
    input  bus64_t      data_vs2_i,   // chunk of vs2
    input  logic [7:0]  data_vm_i,    // mask bit per element of this chunk
    input  logic        use_mask_i,   // carry/borrow-in from mask for VMADC/VMSBC
    output bus64_t      data_vd_o     // result chunk or packed mask bits
);

    logic            inv_vs1;    // subtract vs1 from vs2
    logic            inv_vs2;    // reverse subtract, vs2 is negated
    logic            is_msbc;    // borrow is the inverted carry
    logic [7:0]      elem_seed;  // carry-in for the low byte of each element
    logic [7:0][7:0] byte_a;     // vs2 side, possibly inverted
    logic [7:0][7:0] byte_b;     // vs1 side, possibly inverted
    logic [7:0][7:0] byte_sum;   // byte adder sums
    logic [7:0]      byte_cout;  // byte adder carry-outs
    logic [7:0]      mask_bits;  // packed carry/borrow result
    logic [8:0]      partial;    // one byte adder with its carry
    logic            chain;      // ripple between bytes of one element
    int              bpe;        // bytes per element
    int              n_elem;     // elements per chunk

    assign bpe    = 1 << sew_i;
    assign n_elem = elems_per_chunk(sew_i);

    // a - b is done as a + ~b + 1, the +1 comes in through the seed
    assign inv_vs1 = (instr_type_i == VSUB) || (instr_type_i == VSBC) ||
                     (instr_type_i == VMSBC);
    assign inv_vs2 = (instr_type_i == VRSUB);
    assign is_msbc = (instr_type_i == VMSBC);

    assign byte_a = data_vs2_i ^ {CHUNK_W{inv_vs2}};
    assign byte_b = data_vs1_i ^ {CHUNK_W{inv_vs1}};

    // per-element seed
    // a borrow b turns the +1 of the negation into +(1-b), i.e. ~b
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            case (instr_type_i)
                VADD: begin
                    elem_seed[k] = 1'b0;
                end
                VSUB, VRSUB: begin
                    elem_seed[k] = 1'b1;
                end
                VADC: begin
                    elem_seed[k] = data_vm_i[k];
                end
                VSBC: begin
                    elem_seed[k] = ~data_vm_i[k];
                end
                VMADC: begin
                    elem_seed[k] = use_mask_i & data_vm_i[k]; // no mask, plain carry-out
                end
                VMSBC: begin
                    elem_seed[k] = ~(use_mask_i & data_vm_i[k]);
                end
                default: begin
                    elem_seed[k] = 1'b0;
                end
            endcase
        end
    end

    // byte-sliced ripple
    // the low byte of an element restarts from its seed, the others take
    // the carry of the byte below, so nothing leaks across elements
    always_comb begin
        chain   = 1'b0;
        partial = '0;
        for (int i = 0; i < 8; i++) begin
            if ((i % bpe) == 0) begin
                chain = elem_seed[i >> sew_i]; // element index of byte i
            end
            partial      = {1'b0, byte_a[i]} + {1'b0, byte_b[i]} + {8'd0, chain};
            byte_sum[i]  = partial[7:0];
            byte_cout[i] = partial[8];
            chain        = partial[8];
        end
    end

    // carry-out of an element is the carry of its top byte
    // for VMSBC no carry means the subtraction went below zero
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            mask_bits[k] = 1'b1; // past the element count stays one
            if (k < n_elem) begin
                mask_bits[k] = byte_cout[k * bpe + bpe - 1] ^ is_msbc;
            end
        end
    end

    assign data_vd_o = is_mask_op(instr_type_i) ? {{(CHUNK_W-8){1'b1}}, mask_bits}
                                                : byte_sum;

endmodule

// File: source/vec_addsub_unit.sv
// ----------------------------------------
// vector add/sub unit, top level
// VLEN multiple of 64, whole register done
// result valid with done_o, held until start
// ----------------------------------------
`timescale 1ns/1ps

module vec_addsub_unit
    import vec_pkg::*;
#(
    parameter int VLEN = 256
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              start_i,
    input  instr_type_t       instr_type_i,
    input  sew_t              sew_i,
    input  logic              use_mask_i,
    input  logic [VLEN-1:0]   vs1_i,
    input  logic [VLEN-1:0]   vs2_i,
    input  logic [VLEN/8-1:0] vm_i,      // element k's bit at index k
    output logic              busy_o,
    output logic              done_o,
    output logic [VLEN-1:0]   vd_o
);

    localparam int IDX_W = idx_width(VLEN);

    logic             load;
    logic             clr;
    logic             adv;
    logic             wr_en;
    logic             last;
    logic [IDX_W-1:0] idx;
    instr_type_t      op_q;       // latched operation
    sew_t             sew_q;
    logic             use_mask_q;
    bus64_t           chunk_vs1;
    bus64_t           chunk_vs2;
    logic [7:0]       chunk_vm;
    bus64_t           chunk_vd;   // adder output, registered by the result buffer

    vec_seq_fsm fsm_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .last_i  (last),
        .load_o  (load),
        .clr_o   (clr),
        .adv_o   (adv),
        .wr_en_o (wr_en),
        .busy_o  (busy_o),
        .done_o  (done_o)
    );

    vec_chunk_counter #(.VLEN(VLEN)) cnt_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clr_i   (clr),
        .adv_i   (adv),
        .idx_o   (idx),
        .last_o  (last)
    );

    vec_operand_buf #(.VLEN(VLEN)) opbuf_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .use_mask_i   (use_mask_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vm_i         (vm_i),
        .idx_i        (idx),
        .instr_type_o (op_q),
        .sew_o        (sew_q),
        .use_mask_o   (use_mask_q),
        .chunk_vs1_o  (chunk_vs1),
        .chunk_vs2_o  (chunk_vs2),
        .chunk_vm_o   (chunk_vm)
    );

    vaddsub alu_i (
        .instr_type_i (op_q),
        .sew_i        (sew_q),
        .data_vs1_i   (chunk_vs1),
        .data_vs2_i   (chunk_vs2),
        .data_vm_i    (chunk_vm),
        .use_mask_i   (use_mask_q),
        .data_vd_o    (chunk_vd)
    );

    vec_result_buf #(.VLEN(VLEN)) resbuf_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .wr_en_i      (wr_en),
        .idx_i        (idx),
        .instr_type_i (op_q),
        .sew_i        (sew_q),
        .chunk_vd_i   (chunk_vd),
        .vd_o         (vd_o)
    );

endmodule

// File: source/vec_chunk_counter.sv
// ----------------------------------------
// chunk index, counts 0 .. VLEN/64-1
// holds on the last chunk, no wrap
// ----------------------------------------
`timescale 1ns/1ps

module vec_chunk_counter
    import vec_pkg::*;
#(
    parameter  int VLEN  = 256,
    localparam int IDX_W = idx_width(VLEN)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             clr_i,   // back to chunk 0
    input  logic             adv_i,   // next chunk
    output logic [IDX_W-1:0] idx_o,
    output logic             last_o   // current chunk is the final one
);

    localparam int               N_CHUNK  = VLEN / CHUNK_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_CHUNK - 1);

    logic [IDX_W-1:0] idx_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (clr_i) begin
            idx_q <= '0;
        end else if (adv_i && !last_o) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign idx_o  = idx_q;
    assign last_o = (idx_q == LAST_IDX);

endmodule

// File: source/vec_operand_buf.sv
// ----------------------------------------
// operand and control latch, taken on load
// inputs may change freely after the load
// mask holds one bit per SEW_8 element
// ----------------------------------------
`timescale 1ns/1ps

module vec_operand_buf
    import vec_pkg::*;
#(
    parameter  int VLEN  = 256,
    localparam int IDX_W = idx_width(VLEN)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             load_i,
    input  instr_type_t      instr_type_i,
    input  sew_t             sew_i,
    input  logic             use_mask_i,
    input  logic [VLEN-1:0]  vs1_i,
    input  logic [VLEN-1:0]  vs2_i,
    input  logic [VLEN/8-1:0] vm_i,
    input  logic [IDX_W-1:0] idx_i,        // chunk being processed
    output instr_type_t      instr_type_o,
    output sew_t             sew_o,
    output logic             use_mask_o,
    output bus64_t           chunk_vs1_o,
    output bus64_t           chunk_vs2_o,
    output logic [7:0]       chunk_vm_o    // low n bits valid, rest zero
);

    logic [VLEN-1:0]   vs1_q;
    logic [VLEN-1:0]   vs2_q;
    logic [VLEN/8-1:0] vm_q;
    int                n_elem;  // elements per chunk at the latched width

    // operation controls
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_type_o <= VADD;
            sew_o        <= SEW_8;
            use_mask_o   <= 1'b0;
        end else if (load_i) begin
            instr_type_o <= instr_type_i;
            sew_o        <= sew_i;
            use_mask_o   <= use_mask_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
            vm_q  <= vm_i;
        end
    end

    assign n_elem = elems_per_chunk(sew_o);

    assign chunk_vs1_o = vs1_q[int'(idx_i) * CHUNK_W +: CHUNK_W];
    assign chunk_vs2_o = vs2_q[int'(idx_i) * CHUNK_W +: CHUNK_W];

    // chunk c owns mask bits [c*n, c*n+n)
    always_comb begin
        chunk_vm_o = '0;
        for (int j = 0; j < 8; j++) begin
            if (j < n_elem) begin
                chunk_vm_o[j] = vm_q[int'(idx_i) * n_elem + j];
            end
        end
    end

endmodule

// File: source/vec_pkg.sv
// ----------------------------------------
// shared types for the vector add/sub unit
// VLEN must be a multiple of CHUNK_W (64)
// opcode set covers the add/sub group only
// ----------------------------------------
package vec_pkg;

    localparam int CHUNK_W = 64; // datapath width, one chunk per clock

    typedef logic [CHUNK_W-1:0] bus64_t;

    // opcodes served by this unit
    typedef enum logic [2:0] {
        VADD  = 3'd0, // vs2 + vs1
        VSUB  = 3'd1, // vs2 - vs1
        VRSUB = 3'd2, // vs1 - vs2
        VADC  = 3'd3, // vs2 + vs1 + mask bit
        VSBC  = 3'd4, // vs2 - vs1 - mask bit
        VMADC = 3'd5, // carry-out per element, packed into a mask
        VMSBC = 3'd6  // borrow-out per element, packed into a mask
    } instr_type_t;

    // element width, the encoding doubles as log2 of bytes per element
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // elements that fit in one 64-bit chunk
    function automatic int elems_per_chunk(sew_t sew);
        return 8 >> sew;
    endfunction

    // ops whose result is a packed mask instead of a vector
    function automatic logic is_mask_op(instr_type_t op);
        return (op == VMADC) || (op == VMSBC);
    endfunction

    // width of a chunk index, never below one bit
    function automatic int idx_width(int vlen);
        return (vlen / CHUNK_W > 1) ? $clog2(vlen / CHUNK_W) : 1;
    endfunction

endpackage

// File: source/vec_result_buf.sv
// ----------------------------------------
// destination vector, one chunk per write
// mask ops pack n bits per chunk, tail is one
// value holds until the next load
// ----------------------------------------
`timescale 1ns/1ps

module vec_result_buf
    import vec_pkg::*;
#(
    parameter  int VLEN  = 256,
    localparam int IDX_W = idx_width(VLEN)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             load_i,        // new operation starts
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] idx_i,
    input  instr_type_t      instr_type_i,  // latched opcode
    input  sew_t             sew_i,         // latched width
    input  bus64_t           chunk_vd_i,
    output logic [VLEN-1:0]  vd_o
);

    logic [VLEN-1:0] vd_q;
    int              n_elem;

    assign n_elem = elems_per_chunk(sew_i);

    // preset to ones: mask ops keep the tail, vector ops overwrite every chunk
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vd_q <= '0;
        end else if (load_i) begin
            vd_q <= '1;
        end else if (wr_en_i) begin
            if (is_mask_op(instr_type_i)) begin
                for (int j = 0; j < 8; j++) begin
                    if (j < n_elem) begin
                        vd_q[int'(idx_i) * n_elem + j] <= chunk_vd_i[j]; // packed at idx*n
                    end
                end
            end else begin
                vd_q[int'(idx_i) * CHUNK_W +: CHUNK_W] <= chunk_vd_i;
            end
        end
    end

    assign vd_o = vd_q;

endmodule

// File: source/vec_seq_fsm.sv
// ----------------------------------------
// sequencer, one operation at a time
// start is dropped unless the FSM is idle
// done pulses one cycle after the last chunk
// ----------------------------------------
`timescale 1ns/1ps

module vec_seq_fsm (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,   // one-cycle request
    input  logic last_i,    // counter sits on the final chunk
    output logic load_o,    // latch operands, preset result
    output logic clr_o,     // restart chunk index
    output logic adv_o,     // step chunk index
    output logic wr_en_o,   // write current chunk result
    output logic busy_o,
    output logic done_o
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1, // one chunk per cycle
        DONE = 2'd2  // last chunk is in the result buffer
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   accept;  // start taken this cycle
    logic   done_q;

    assign accept = (state_q == IDLE) && start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (last_i) begin
                    state_d = DONE; // final chunk written at this edge
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == DONE); // lines up with the fall of busy
        end
    end

    assign load_o  = accept;
    assign clr_o   = accept;
    assign adv_o   = (state_q == RUN);
    assign wr_en_o = (state_q == RUN);
    assign busy_o  = (state_q != IDLE);
    assign done_o  = done_q;

endmodule

// File: vec_addsub_unit.f
source/vec_pkg.sv
source/vaddsub.sv
source/vec_seq_fsm.sv
source/vec_chunk_counter.sv
source/vec_operand_buf.sv
source/vec_result_buf.sv
source/vec_addsub_unit.sv
bench/vec_clk_gen.sv
bench/vec_addsub_tb.sv
